//--- include/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// first fetch address out of reset
`define RESET_PC 64'h0000_0000_8000_0000

// trap vector base out of reset, direct mode
`define RESET_MTVEC 64'h0000_0000_8000_0100

// instruction memory size in 64-bit words
// word index comes from address bits 10:3
`define IMEM_WORDS 256

// cycles from address accept to data valid
`define IMEM_LATENCY 2

`endif

//--- design/fetch_pkg.sv
package fetch_pkg;

    // one memory word, seen either as raw data or as two instruction slots
    // lo sits at the lower address (pc bit 2 clear)
    typedef union packed {
        logic [63:0] raw;
        struct packed {
            logic [31:0] hi;
            logic [31:0] lo;
        } slot;
    } mem_word_u;

    // source of the target pc update in the current cycle
    typedef enum logic [2:0] {
        REDIR_NONE   = 3'd0,
        REDIR_JAL    = 3'd1,
        REDIR_BRANCH = 3'd2,
        REDIR_JALR   = 3'd3,
        REDIR_TRAP   = 3'd4
    } redirect_kind_e;

endpackage

//--- design/imem_read_if.sv
`timescale 1ns/1ps

interface imem_read_if
    import fetch_pkg::*;
();
    // address phase
    logic        addr_valid;
    logic        addr_ready;
    logic [63:0] addr;

    // data phase
    logic        data_valid;
    logic        data_ready;
    mem_word_u   data;

    modport master (
        output addr_valid,
        output addr,
        input  addr_ready,
        input  data_valid,
        input  data,
        output data_ready
    );

    modport slave (
        input  addr_valid,
        input  addr,
        output addr_ready,
        output data_valid,
        output data,
        input  data_ready
    );

endinterface

//--- design/trap_vector_regs.sv
`timescale 1ns/1ps

`include "fetch_defines.svh"

module trap_vector_regs (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        we_i,
    input  logic [63:0] wdata_i,
    output logic [63:0] mtvec_o
);

    logic [63:0] mtvec_q;

    // only direct mode, mode bits always read back as zero
    always_ff @(posedge clk) begin
        if (rst_i) begin
            mtvec_q <= `RESET_MTVEC;
        end else if (we_i) begin
            mtvec_q <= {wdata_i[63:2], 2'b00};
        end
    end

    assign mtvec_o = mtvec_q;

endmodule

//--- design/pc_redirect.sv
`timescale 1ns/1ps

`include "fetch_defines.svh"

module pc_redirect
    import fetch_pkg::*;
(
    input  logic           clk,
    input  logic           rst_i,
    input  logic           me_jal_i,
    input  logic           me_jalr_i,
    input  logic           me_branch_i,
    input  logic           trap_i,
    input  logic [63:0]    me_alu_res_i,
    input  logic [63:0]    me_pc_i,
    input  logic [63:0]    me_imm_i,
    input  logic [63:0]    me_rs1_data_i,
    input  logic [63:0]    mtvec_i,
    input  logic           advance_i,
    output logic [63:0]    target_pc_o,
    output redirect_kind_e redirect_kind_o
);

    logic        branch_taken;
    logic [63:0] jal_target;
    logic [63:0] jalr_sum;
    logic [63:0] jalr_target;
    logic [63:0] target_d;

    // branch compare result of zero means taken
    assign branch_taken = me_branch_i && (me_alu_res_i == 64'd0);
    assign jal_target   = me_pc_i + me_imm_i;
    assign jalr_sum     = me_rs1_data_i + me_imm_i;
    assign jalr_target  = {jalr_sum[63:1], 1'b0};

    // memory stage redirects first, then trap, then sequential step
    always_comb begin
        redirect_kind_o = REDIR_NONE;
        target_d        = target_pc_o;
        if (me_jal_i) begin
            redirect_kind_o = REDIR_JAL;
            target_d        = jal_target;
        end else if (branch_taken) begin
            redirect_kind_o = REDIR_BRANCH;
            target_d        = jal_target;
        end else if (me_jalr_i) begin
            redirect_kind_o = REDIR_JALR;
            target_d        = jalr_target;
        end else if (trap_i) begin
            redirect_kind_o = REDIR_TRAP;
            target_d        = mtvec_i;
        end else if (advance_i) begin
            target_d = target_pc_o + 64'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            target_pc_o <= `RESET_PC;
        end else begin
            target_pc_o <= target_d;
        end
    end

endmodule

//--- design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_i,
    input  logic        stall_i,
    input  logic [63:0] target_pc_i,
    imem_read_if.master bus,
    output logic        advance_o,
    output logic [31:0] inst_o,
    output logic [63:0] pc_o,
    output logic        inst_valid_o
);

    // request sequence: issue, wait address accept, wait data
    localparam logic [1:0] S_ISSUE = 2'd0;
    localparam logic [1:0] S_ADDR  = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;

    logic [1:0]  state_q;
    logic        addr_valid_q;
    logic        data_ready_q;
    logic [63:0] req_addr_q;
    mem_word_u   rsp_word;
    logic        issue;
    logic        data_fire;
    logic        rsp_match;

    assign issue = (state_q == S_ISSUE) && !stall_i;

    assign bus.addr_valid = addr_valid_q;
    assign bus.addr       = req_addr_q;
    assign bus.data_ready = data_ready_q;

    assign rsp_word  = bus.data;
    assign data_fire = bus.data_valid && bus.data_ready;

    // response is only useful if the target did not move meanwhile
    assign rsp_match = (req_addr_q == target_pc_i);

    // target steps by 4 at the edge closing the transfer
    assign advance_o = data_fire && rsp_match;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q      <= S_ISSUE;
            addr_valid_q <= 1'b0;
            data_ready_q <= 1'b0;
            inst_valid_o <= 1'b0;
        end else begin
            inst_valid_o <= 1'b0;
            case (state_q)
                S_ISSUE: begin
                    if (issue) begin
                        addr_valid_q <= 1'b1;
                        state_q      <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    // address taken, ready for data from next cycle
                    if (bus.addr_ready) begin
                        addr_valid_q <= 1'b0;
                        data_ready_q <= 1'b1;
                        state_q      <= S_DATA;
                    end
                end
                S_DATA: begin
                    // stale words are dropped, next issue uses the new target
                    if (data_fire) begin
                        data_ready_q <= 1'b0;
                        inst_valid_o <= rsp_match;
                        state_q      <= S_ISSUE;
                    end
                end
                default: begin
                    state_q <= S_ISSUE;
                end
            endcase
        end
    end

    // request address held until the read completes
    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr_q <= target_pc_i;
        end
    end

    // pc bit 2 picks the upper slot
    always_ff @(posedge clk) begin
        if (data_fire && rsp_match) begin
            inst_o <= req_addr_q[2] ? rsp_word.slot.hi : rsp_word.slot.lo;
            pc_o   <= req_addr_q;
        end
    end

endmodule

//--- design/inst_mem.sv
`timescale 1ns/1ps

`include "fetch_defines.svh"

module inst_mem
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_i,
    input  logic        we_i,
    input  logic [63:0] waddr_i,
    input  logic [63:0] wdata_i,
    imem_read_if.slave  bus
);

    localparam int IDX_W = $clog2(`IMEM_WORDS);
    localparam int CNT_W = $clog2(`IMEM_LATENCY + 1);

    mem_word_u        mem [`IMEM_WORDS];
    mem_word_u        rd_word_q;
    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic [IDX_W-1:0] waddr_idx;
    logic [IDX_W-1:0] raddr_idx;
    logic             addr_fire;
    logic             data_fire;

    // byte address to word index, upper bits ignored
    assign waddr_idx = waddr_i[3 +: IDX_W];
    assign raddr_idx = bus.addr[3 +: IDX_W];

    // accept an address whenever no read is pending
    assign bus.addr_ready = !busy_q;
    assign addr_fire      = bus.addr_valid && bus.addr_ready;

    assign bus.data_valid = busy_q && (cnt_q == '0);
    assign bus.data       = rd_word_q;
    assign data_fire      = bus.data_valid && bus.data_ready;

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_idx].raw <= wdata_i;
        end
    end

    // word captured at address accept
    always_ff @(posedge clk) begin
        if (addr_fire) begin
            rd_word_q <= mem[raddr_idx];
        end
    end

    // latency countdown, data held until the master takes it
    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (addr_fire) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(`IMEM_LATENCY - 1);
        end else if (data_fire) begin
            busy_q <= 1'b0;
        end else if (busy_q && (cnt_q != '0)) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

endmodule

//--- design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic           clk,
    input  logic           rst_i,
    input  logic           mtvec_we_i,
    input  logic [63:0]    mtvec_wdata_i,
    input  logic           imem_we_i,
    input  logic [63:0]    imem_waddr_i,
    input  logic [63:0]    imem_wdata_i,
    input  logic           me_jal_i,
    input  logic           me_jalr_i,
    input  logic           me_branch_i,
    input  logic           trap_i,
    input  logic [63:0]    me_alu_res_i,
    input  logic [63:0]    me_pc_i,
    input  logic [63:0]    me_imm_i,
    input  logic [63:0]    me_rs1_data_i,
    input  logic           stall_i,
    output logic [31:0]    inst_o,
    output logic [63:0]    pc_o,
    output logic           inst_valid_o,
    output redirect_kind_e redirect_kind_o
);

    logic [63:0] mtvec;
    logic [63:0] target_pc;
    logic        advance;

    imem_read_if imem_bus ();

    trap_vector_regs u_trap_vector_regs (
        .clk     (clk),
        .rst_i   (rst_i),
        .we_i    (mtvec_we_i),
        .wdata_i (mtvec_wdata_i),
        .mtvec_o (mtvec)
    );

    pc_redirect u_pc_redirect (
        .clk             (clk),
        .rst_i           (rst_i),
        .me_jal_i        (me_jal_i),
        .me_jalr_i       (me_jalr_i),
        .me_branch_i     (me_branch_i),
        .trap_i          (trap_i),
        .me_alu_res_i    (me_alu_res_i),
        .me_pc_i         (me_pc_i),
        .me_imm_i        (me_imm_i),
        .me_rs1_data_i   (me_rs1_data_i),
        .mtvec_i         (mtvec),
        .advance_i       (advance),
        .target_pc_o     (target_pc),
        .redirect_kind_o (redirect_kind_o)
    );

    fetch_unit u_fetch_unit (
        .clk          (clk),
        .rst_i        (rst_i),
        .stall_i      (stall_i),
        .target_pc_i  (target_pc),
        .bus          (imem_bus.master),
        .advance_o    (advance),
        .inst_o       (inst_o),
        .pc_o         (pc_o),
        .inst_valid_o (inst_valid_o)
    );

    inst_mem u_inst_mem (
        .clk     (clk),
        .rst_i   (rst_i),
        .we_i    (imem_we_i),
        .waddr_i (imem_waddr_i),
        .wdata_i (imem_wdata_i),
        .bus     (imem_bus.slave)
    );

endmodule

//--- testbench/fetch_properties.sv
`timescale 1ns/1ps

module fetch_properties (
    input logic        clk,
    input logic        rst_i,
    input logic        stall_i,
    input logic        addr_valid_i,
    input logic        addr_ready_i,
    input logic [63:0] addr_i,
    input logic        data_valid_i,
    input logic        data_ready_i,
    input logic        inst_valid_i
);

    logic read_open;
    int   fail_count = 0;

    // open from address accept until the data is taken
    always_ff @(posedge clk) begin
        if (rst_i) begin
            read_open <= 1'b0;
        end else if (addr_valid_i && addr_ready_i) begin
            read_open <= 1'b1;
        end else if (data_valid_i && data_ready_i) begin
            read_open <= 1'b0;
        end
    end

    // request address holds from issue until its data is taken
    addr_stable_a: assert property (@(posedge clk) disable iff (rst_i)
        (addr_valid_i || (read_open && !(data_valid_i && data_ready_i))) |=> $stable(addr_i))
        else begin
            $error("read address changed while the read was pending");
            fail_count++;
        end

    inst_valid_pulse_a: assert property (@(posedge clk) disable iff (rst_i)
        inst_valid_i |=> !inst_valid_i)
        else begin
            $error("instruction valid held longer than one cycle");
            fail_count++;
        end

    no_issue_in_stall_a: assert property (@(posedge clk) disable iff (rst_i)
        (stall_i && !addr_valid_i) |=> !addr_valid_i)
        else begin
            $error("read request raised while stalled");
            fail_count++;
        end

    data_after_addr_a: assert property (@(posedge clk) disable iff (rst_i)
        data_valid_i |-> read_open)
        else begin
            $error("read data offered with no accepted address");
            fail_count++;
        end

endmodule

//--- testbench/fetch_tb.sv
`timescale 1ns/1ps

`include "fetch_defines.svh"

module fetch_tb
    import fetch_pkg::*;
();

    localparam int NUM_INST = 2000;
    // preload plus 4 cycles per instruction with a 4x margin
    localparam int TIMEOUT_CYCLES = `IMEM_WORDS + 8 + NUM_INST * 4 * 4;

    logic           clk, rst_i, stall_i, mtvec_we_i, imem_we_i;
    logic           me_jal_i, me_jalr_i, me_branch_i, trap_i, inst_valid_o;
    logic [63:0]    mtvec_wdata_i, imem_waddr_i, imem_wdata_i, pc_o;
    logic [63:0]    me_alu_res_i, me_pc_i, me_imm_i, me_rs1_data_i;
    logic [31:0]    inst_o;
    redirect_kind_e redirect_kind_o;

    integer         seed = 32'h8da1;
    int             cycle_cnt = 0;
    int             delivered = 0;
    int             stale_drops = 0;
    logic [4:0]     kinds_seen = '0;
    mem_word_u      shadow [`IMEM_WORDS];

    // reference model state
    logic [63:0]    m_target, m_mtvec, m_req, exp_pc;
    int             m_phase, m_wait;
    logic           exp_valid;
    logic [31:0]    exp_inst;
    redirect_kind_e exp_kind;

    fetch_top dut_i (.*);

    bind fetch_unit fetch_properties props_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .stall_i      (stall_i),
        .addr_valid_i (bus.addr_valid),
        .addr_ready_i (bus.addr_ready),
        .addr_i       (bus.addr),
        .data_valid_i (bus.data_valid),
        .data_ready_i (bus.data_ready),
        .inst_valid_i (inst_valid_o)
    );

    always #50 clk = ~clk;

    task automatic stop_on_error();
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout: only %0d instructions after %0d cycles", delivered, cycle_cnt);
            stop_on_error();
        end
    end

    task automatic check_valid(input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR inst_valid_o expected %h actual %h", exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_inst(input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR inst_o expected %h actual %h", exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_pc(input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("ERROR pc_o expected %h actual %h", exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_kind(input redirect_kind_e exp, input redirect_kind_e act);
        if (act !== exp) begin
            $display("ERROR redirect_kind_o expected %h actual %h", exp, act);
            stop_on_error();
        end
    endtask

    task automatic preload_memory();
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            @(negedge clk);
            imem_we_i     = 1'b1;
            imem_waddr_i  = `RESET_PC + 64'(i * 8);
            imem_wdata_i  = {$random(seed), $random(seed)};
            shadow[i].raw = imem_wdata_i;
        end
    endtask

    // redirect about one cycle in twelve, any mix of sources
    task automatic drive_inputs();
        logic [31:0] r;
        imem_we_i     = 1'b0;
        stall_i       = ({$random(seed)} % 8) == 0;
        r             = (({$random(seed)} % 12) == 0) ? $random(seed) : 32'd0;
        me_jal_i      = r[0];
        me_jalr_i     = r[1];
        me_branch_i   = r[2];
        trap_i        = r[3];
        me_alu_res_i  = r[4] ? 64'd0 : {32'd0, $random(seed)} | 64'd1;
        me_pc_i       = `RESET_PC + ({$random(seed)} & 32'h7fc);
        me_rs1_data_i = `RESET_PC + ({$random(seed)} & 32'h7ff);
        r             = $random(seed);
        me_imm_i      = {{52{r[11]}}, r[11:2], 2'b00};
        mtvec_we_i    = ({$random(seed)} % 40) == 0;
        mtvec_wdata_i = `RESET_PC + ({$random(seed)} & 32'h7ff);
    endtask

    // jal, then taken branch, then jalr, then trap
    function automatic redirect_kind_e expected_kind();
        if (me_jal_i) return REDIR_JAL;
        if (me_branch_i && me_alu_res_i == 64'd0) return REDIR_BRANCH;
        if (me_jalr_i) return REDIR_JALR;
        if (trap_i) return REDIR_TRAP;
        return REDIR_NONE;
    endfunction

    // what the coming clock edge does, from the inputs driven this cycle
    task automatic step_model();
        mem_word_u word;
        logic      advance;
        advance   = 1'b0;
        exp_valid = 1'b0;
        if (m_phase == 0) begin
            if (!stall_i) begin
                m_req   = m_target;
                m_phase = 1;
            end
        end else if (m_phase == 1) begin
            m_wait  = `IMEM_LATENCY;
            m_phase = 2;
        end else if (m_wait > 1) begin
            m_wait--;
        end else begin
            m_phase = 0;
            if (m_req == m_target) begin
                // little endian, upper half when pc bit 2 is set
                word      = shadow[m_req[10:3]];
                exp_inst  = m_req[2] ? word.raw[63:32] : word.raw[31:0];
                exp_pc    = m_req;
                exp_valid = 1'b1;
                advance   = 1'b1;
            end else begin
                stale_drops++;
            end
        end
        case (exp_kind)
            REDIR_JAL, REDIR_BRANCH: m_target = me_pc_i + me_imm_i;
            REDIR_JALR: m_target = (me_rs1_data_i + me_imm_i) & ~64'd1;
            REDIR_TRAP: m_target = m_mtvec;
            default: m_target = advance ? m_target + 64'd4 : m_target;
        endcase
        if (mtvec_we_i) begin
            m_mtvec = mtvec_wdata_i & ~64'd3;
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_i = 1'b1;
        stall_i = 1'b1;
        {mtvec_we_i, imem_we_i, me_jal_i, me_jalr_i, me_branch_i, trap_i} = '0;
        {mtvec_wdata_i, imem_waddr_i, imem_wdata_i} = '0;
        {me_alu_res_i, me_pc_i, me_imm_i, me_rs1_data_i} = '0;
        m_target  = `RESET_PC;
        m_mtvec   = `RESET_MTVEC;
        m_phase   = 0;
        exp_valid = 1'b0;
        repeat (3) @(negedge clk);
        rst_i = 1'b0;
        // stall stays high so nothing is fetched before the memory is filled
        preload_memory();
        while (delivered < NUM_INST) begin
            @(negedge clk);
            if (dut_i.u_fetch_unit.props_i.fail_count != 0) begin
                $display("a bound assertion on the fetch unit failed");
                stop_on_error();
            end
            check_valid(exp_valid, inst_valid_o);
            if (exp_valid) begin
                check_inst(exp_inst, inst_o);
                check_pc(exp_pc, pc_o);
                delivered++;
            end
            drive_inputs();
            exp_kind = expected_kind();
            #1;
            check_kind(exp_kind, redirect_kind_o);
            kinds_seen[int'(exp_kind)] = 1'b1;
            step_model();
        end
        if (stale_drops == 0 || kinds_seen != 5'h1f) begin
            $display("some redirect kinds or stale responses were never exercised");
            stop_on_error();
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- src.f
+incdir+include
design/fetch_pkg.sv
design/imem_read_if.sv
design/trap_vector_regs.sv
design/pc_redirect.sv
design/fetch_unit.sv
design/inst_mem.sv
design/fetch_top.sv
testbench/fetch_properties.sv
testbench/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_stage

export_include_dirs:
  - include

sources:
  - files:
      - design/fetch_pkg.sv
      - design/imem_read_if.sv
      - design/trap_vector_regs.sv
      - design/pc_redirect.sv
      - design/fetch_unit.sv
      - design/inst_mem.sv
      - design/fetch_top.sv
  - target: test
    files:
      - testbench/fetch_properties.sv
      - testbench/fetch_tb.sv
